//--- rtl/elevator_pkg.sv
// Shared floor and queue sizes, vector types and request/dispatch structs

package elevator_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // Floors served by the car, numbered from 0 at the bottom
    localparam int num_floors = 11;

    // Request FIFO entries, above the 22 lights that can be lit at once
    localparam int queue_depth = 32;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [$clog2(queue_depth)-1:0] queue_index_t;
    typedef logic [3:0]                     floor_t;

    // One bit per floor for buttons and lights
    typedef logic [num_floors-1:0]          floor_mask_t;

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////

    // Car position as reported by the car
    typedef struct packed {
        floor_t current_floor;
        logic   moving;
    } car_status_t;

    // One accepted request, valid for a single cycle
    typedef struct packed {
        logic   push;
        floor_t floor;
    } floor_request_t;

    // Command toward the car
    typedef struct packed {
        logic   activate;
        logic   up;
        floor_t target;
    } dispatch_t;

endpackage

//--- rtl/request_latch.sv
// Button sampling, request lights and the single accepted request per cycle

`timescale 1ns/1ps

module request_latch (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        power_switch,
    input  logic                        emergency_btn,
    input  elevator_pkg::floor_mask_t   call_buttons,
    input  elevator_pkg::floor_mask_t   panel_buttons,
    input  elevator_pkg::car_status_t   car_status,
    output elevator_pkg::floor_mask_t   call_lights,
    output elevator_pkg::floor_mask_t   panel_lights,
    output elevator_pkg::floor_request_t new_request
);
    import elevator_pkg::*;

    logic        accept_enable;
    floor_mask_t here_mask;
    floor_mask_t clear_mask;
    floor_mask_t call_eligible;
    floor_mask_t panel_eligible;
    floor_mask_t call_pick;
    floor_mask_t panel_pick;
    logic        pick_valid;
    floor_t      pick_floor;
    logic        push_q;
    floor_t      floor_q;

    ////////////////////////////////////////
    // Eligibility and priority
    ////////////////////////////////////////

    assign accept_enable = power_switch && !emergency_btn;

    // One-hot of the floor the car is at
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            here_mask[i] = (car_status.current_floor == floor_t'(i));
        end
    end

    assign call_eligible  = call_buttons & ~call_lights & ~here_mask
                          & {num_floors{accept_enable}};
    assign panel_eligible = panel_buttons & ~panel_lights & ~here_mask
                          & {num_floors{accept_enable}};

    // Lowest set bit wins, hall calls ahead of the car panel
    assign call_pick  = call_eligible & (~call_eligible + floor_mask_t'(1));
    assign panel_pick = (call_eligible == '0) ?
                        (panel_eligible & (~panel_eligible + floor_mask_t'(1))) : '0;
    assign pick_valid = |(call_pick | panel_pick);

    // Encode the winning one-hot bit as a floor number
    always_comb begin
        pick_floor = '0;
        for (int i = 0; i < num_floors; i++) begin
            if (call_pick[i] || panel_pick[i]) begin
                pick_floor = floor_t'(i);
            end
        end
    end

    ////////////////////////////////////////
    // Lights and request register
    ////////////////////////////////////////

    // Power off drops everything, a stopped car serves its own floor
    assign clear_mask = !power_switch      ? '1 :
                        car_status.moving  ? '0 : here_mask;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
            push_q       <= 1'b0;
        end else begin
            call_lights  <= (call_lights | call_pick) & ~clear_mask;
            panel_lights <= (panel_lights | panel_pick) & ~clear_mask;
            push_q       <= pick_valid;
        end
    end

    always_ff @(posedge clock) begin
        floor_q <= pick_floor;
    end

    assign new_request = '{push: push_q, floor: floor_q};

endmodule

//--- rtl/request_queue.sv
// FIFO of accepted floor requests, popped when the car stops at the head floor

`timescale 1ns/1ps

module request_queue (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         power_switch,
    input  elevator_pkg::floor_request_t new_request,
    input  elevator_pkg::car_status_t    car_status,
    output logic                         head_valid,
    output elevator_pkg::floor_t         head_floor
);
    import elevator_pkg::*;

    floor_t                            entries [queue_depth];
    queue_index_t                      wr_ptr;
    queue_index_t                      rd_ptr;
    logic [$clog2(queue_depth+1)-1:0]  count;
    logic                              do_push;
    logic                              do_pop;

    ////////////////////////////////////////
    // Head and strobes
    ////////////////////////////////////////

    assign head_valid = (count != '0);
    assign head_floor = entries[rd_ptr];

    // Requests arriving as the power drops are discarded
    assign do_push = new_request.push && power_switch;

    // Served once the car sits still at the head floor
    assign do_pop  = head_valid && !car_status.moving &&
                     (head_floor == car_status.current_floor);

    ////////////////////////////////////////
    // Pointers and count
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (!power_switch) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + queue_index_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + queue_index_t'(1);
            end
            // Push and pop together leave the count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr] <= new_request.floor;
        end
    end

endmodule

//--- rtl/car_dispatch.sv
// Registered floor target, direction, activate strobe and door permissions

`timescale 1ns/1ps

module car_dispatch (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      power_switch,
    input  logic                      emergency_btn,
    input  logic                      door_open_btn,
    input  logic                      door_close_btn,
    input  elevator_pkg::car_status_t car_status,
    input  logic                      head_valid,
    input  elevator_pkg::floor_t      head_floor,
    output elevator_pkg::dispatch_t   dispatch,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);
    import elevator_pkg::*;

    logic   car_idle;
    logic   go_next;
    logic   activate_q;
    logic   up_q;
    floor_t target_q;

    // Stopped with power on, the only time the car may start or the doors move
    assign car_idle = power_switch && !car_status.moving;

    // A pending request for some other floor and no emergency
    assign go_next  = car_idle && !emergency_btn && head_valid &&
                      (head_floor != car_status.current_floor);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            activate_q         <= 1'b0;
            up_q               <= 1'b0;
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            activate_q         <= go_next;
            up_q               <= head_valid && (head_floor > car_status.current_floor);
            door_open_allowed  <= car_idle && door_open_btn;
            door_close_allowed <= car_idle && door_close_btn;
        end
    end

    always_ff @(posedge clock) begin
        target_q <= head_floor;
    end

    assign dispatch = '{activate: activate_q, up: up_q, target: target_q};

endmodule

//--- rtl/floor_request_controller.sv
// Top level joining the button latch, request FIFO and car dispatch

`timescale 1ns/1ps

module floor_request_controller (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      power_switch,
    input  logic                      emergency_btn,
    input  logic                      door_open_btn,
    input  logic                      door_close_btn,
    input  elevator_pkg::floor_mask_t call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  elevator_pkg::car_status_t car_status,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights,
    output elevator_pkg::dispatch_t   dispatch,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);
    import elevator_pkg::*;

    floor_request_t new_request;
    logic           head_valid;
    floor_t         head_floor;

    // Buttons in, one request per cycle out
    request_latch u_request_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .car_status    (car_status),
        .call_lights   (call_lights),
        .panel_lights  (panel_lights),
        .new_request   (new_request)
    );

    request_queue u_request_queue (
        .clock        (clock),
        .reset_n      (reset_n),
        .power_switch (power_switch),
        .new_request  (new_request),
        .car_status   (car_status),
        .head_valid   (head_valid),
        .head_floor   (head_floor)
    );

    // Oldest request drives the car
    car_dispatch u_car_dispatch (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .car_status         (car_status),
        .head_valid         (head_valid),
        .head_floor         (head_floor),
        .dispatch           (dispatch),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

//--- bench/floor_request_controller_tb.sv
// Testbench with clock, reset, stimulus, car model, reference model, assertions and watchdog

`timescale 1ns/1ps

module floor_request_controller_tb;
    import elevator_pkg::*;

    localparam int clock_period  = 100;
    localparam int reset_cycles  = 8;
    localparam int step_cycles   = 2;
    localparam int random_cycles = 400;
    localparam int idle_budget   = 300;
    localparam int test_cycles   = reset_cycles + 120 + random_cycles + 7 * idle_budget;
    localparam int margin_cycles = 500;

    logic clock, reset_n, power_switch, emergency_btn, door_open_btn, door_close_btn;
    floor_mask_t call_buttons, panel_buttons, call_lights, panel_lights;
    car_status_t car_status;
    dispatch_t   dispatch;
    logic        door_open_allowed, door_close_allowed;

    // Reference model state
    floor_mask_t model_call_lights, model_panel_lights;
    floor_t      model_queue [$];
    int          model_count;
    logic        model_push_pending;
    floor_t      model_push_floor;
    logic        exp_activate, exp_up, exp_door_open, exp_door_close;
    floor_t      exp_target;
    floor_t      car_target;
    int          step_count;
    logic [31:0] rand_state;

    floor_request_controller UUT (
        .clock (clock), .reset_n (reset_n), .power_switch (power_switch),
        .emergency_btn (emergency_btn), .door_open_btn (door_open_btn),
        .door_close_btn (door_close_btn), .call_buttons (call_buttons),
        .panel_buttons (panel_buttons), .car_status (car_status),
        .call_lights (call_lights), .panel_lights (panel_lights), .dispatch (dispatch),
        .door_open_allowed (door_open_allowed), .door_close_allowed (door_close_allowed)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic floor_mask_t floor_bit(input floor_t floor);
        return floor_mask_t'(1) << floor;
    endfunction

    function automatic logic outputs_low();
        return (call_lights == '0) && (panel_lights == '0) && !dispatch.activate &&
               !dispatch.up && !door_open_allowed && !door_close_allowed;
    endfunction

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    ////////////////////////////////////////
    // Car model
    ////////////////////////////////////////

    // One floor per step_cycles toward the target latched on activate
    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            car_status <= '0;
            car_target <= '0;
            step_count <= 0;
        end else if (!car_status.moving) begin
            if (dispatch.activate) begin
                car_status.moving <= 1'b1;
                car_target        <= dispatch.target;
                step_count        <= 0;
            end
        end else if (step_count == step_cycles - 1) begin
            step_count <= 0;
            if (car_status.current_floor == car_target) begin
                car_status.moving <= 1'b0;
            end else if (car_target > car_status.current_floor) begin
                car_status.current_floor <= car_status.current_floor + 1'b1;
            end else begin
                car_status.current_floor <= car_status.current_floor - 1'b1;
            end
        end else begin
            step_count <= step_count + 1;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    always @(posedge clock or negedge reset_n) begin : reference_model
        floor_mask_t next_call;
        floor_mask_t next_panel;
        floor_t      cur;
        logic        allowed;
        logic        taken;
        floor_t      taken_floor;
        if (!reset_n) begin
            model_call_lights  <= '0;
            model_panel_lights <= '0;
            model_queue.delete();
            model_count        <= 0;
            model_push_pending <= 1'b0;
            model_push_floor   <= '0;
            exp_activate       <= 1'b0;
            exp_up             <= 1'b0;
            exp_target         <= '0;
            exp_door_open      <= 1'b0;
            exp_door_close     <= 1'b0;
        end else begin
            cur     = car_status.current_floor;
            allowed = power_switch && !emergency_btn;
            // Dispatch follows the queue as it stood before this edge
            exp_activate   <= allowed && !car_status.moving && model_queue.size() != 0 &&
                              model_queue[0] != cur;
            exp_up         <= model_queue.size() != 0 && model_queue[0] > cur;
            if (model_queue.size() != 0) begin
                exp_target <= model_queue[0];
            end
            exp_door_open  <= power_switch && !car_status.moving && door_open_btn;
            exp_door_close <= power_switch && !car_status.moving && door_close_btn;
            // Hall calls first, lowest floor first
            next_call   = model_call_lights;
            next_panel  = model_panel_lights;
            taken       = 1'b0;
            taken_floor = '0;
            for (int i = 0; i < num_floors; i++) begin
                if (!taken && allowed && call_buttons[i] && !model_call_lights[i] &&
                    floor_t'(i) != cur) begin
                    next_call[i] = 1'b1;
                    taken        = 1'b1;
                    taken_floor  = floor_t'(i);
                end
            end
            for (int i = 0; i < num_floors; i++) begin
                if (!taken && allowed && panel_buttons[i] && !model_panel_lights[i] &&
                    floor_t'(i) != cur) begin
                    next_panel[i] = 1'b1;
                    taken         = 1'b1;
                    taken_floor   = floor_t'(i);
                end
            end
            if (!power_switch) begin
                next_call  = '0;
                next_panel = '0;
                model_queue.delete();
            end else begin
                if (!car_status.moving) begin
                    next_call[cur]  = 1'b0;
                    next_panel[cur] = 1'b0;
                end
                if (model_queue.size() != 0 && !car_status.moving && model_queue[0] == cur) begin
                    void'(model_queue.pop_front());
                end
                if (model_push_pending) begin
                    model_queue.push_back(model_push_floor);
                end
            end
            model_call_lights  <= next_call;
            model_panel_lights <= next_panel;
            model_count        <= model_queue.size();
            model_push_pending <= taken;
            model_push_floor   <= taken_floor;
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    assert property (@(posedge clock) disable iff (!reset_n)
        call_lights == model_call_lights && panel_lights == model_panel_lights)
        else fail_check("request lights differ from the light model");
    assert property (@(posedge clock) disable iff (!reset_n)
        $countones({call_lights, panel_lights} & ~$past({call_lights, panel_lights})) <= 1)
        else fail_check("more than one new light in a cycle");
    assert property (@(posedge clock) disable iff (!reset_n)
        dispatch.activate == exp_activate && dispatch.up == exp_up)
        else fail_check("activate or up differs from the queue model");
    assert property (@(posedge clock) disable iff (!reset_n)
        exp_activate |-> dispatch.target == exp_target)
        else fail_check("target is not the oldest queued floor");
    assert property (@(posedge clock) disable iff (!reset_n)
        $past(!car_status.moving) |->
        ((call_lights | panel_lights) & floor_bit($past(car_status.current_floor))) == '0)
        else fail_check("light of the floor where the car stopped is still on");
    assert property (@(posedge clock) disable iff (!reset_n)
        $past(emergency_btn) |-> !dispatch.activate &&
        ({call_lights, panel_lights} & ~$past({call_lights, panel_lights})) == '0)
        else fail_check("new light or activate during emergency");
    assert property (@(posedge clock) disable iff (!reset_n)
        $past(!power_switch) |-> call_lights == '0 && panel_lights == '0 &&
        !UUT.u_request_queue.head_valid)
        else fail_check("lights or queue not cleared after power off");
    assert property (@(posedge clock) disable iff (!reset_n)
        door_open_allowed == exp_door_open && door_close_allowed == exp_door_close)
        else fail_check("door permission differs from its button");
    assert property (@(posedge clock) disable iff (!reset_n)
        $past(car_status.moving || !power_switch) |-> !door_open_allowed && !door_close_allowed)
        else fail_check("door permission while moving or unpowered");

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic drive_buttons(input floor_mask_t calls, input floor_mask_t panels,
                                 input int cycles);
        @(posedge clock);
        call_buttons  <= calls;
        panel_buttons <= panels;
        repeat (cycles) @(posedge clock);
        call_buttons  <= '0;
        panel_buttons <= '0;
    endtask

    // Queue drained and car parked
    task automatic wait_idle();
        repeat (3) @(posedge clock);
        while (model_count != 0 || model_push_pending || car_status.moving) begin
            @(posedge clock);
        end
    endtask

    initial begin
        floor_t press_floor;
        reset_n = 1'b0;
        power_switch = 1'b1;
        emergency_btn = 1'b0;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        call_buttons = '0;
        panel_buttons = '0;
        car_status = '0;
        rand_state = 32'hdd33;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        assert (outputs_low()) else fail_check("outputs not low during reset");
        @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        assert (outputs_low()) else fail_check("outputs not low after reset release");

        // Presses at the floor the car is parked on
        drive_buttons(floor_bit(4'd0), floor_bit(4'd0), 3);
        drive_buttons(floor_bit(4'd5), '0, 1);
        wait_idle();
        drive_buttons(floor_bit(4'd2) | floor_bit(4'd7),
                      floor_bit(4'd0) | floor_bit(4'd3) | floor_bit(4'd9), 6);
        wait_idle();

        // Doors while parked, then while travelling
        @(posedge clock);
        door_open_btn <= 1'b1;
        repeat (3) @(posedge clock);
        door_open_btn  <= 1'b0;
        door_close_btn <= 1'b1;
        repeat (3) @(posedge clock);
        door_close_btn <= 1'b0;
        drive_buttons(floor_bit(4'd8), '0, 1);
        while (!car_status.moving) @(posedge clock);
        door_open_btn  <= 1'b1;
        door_close_btn <= 1'b1;
        repeat (4) @(posedge clock);
        door_open_btn  <= 1'b0;
        door_close_btn <= 1'b0;
        wait_idle();

        drive_buttons(floor_bit(4'd1), '0, 1);
        emergency_btn <= 1'b1;
        drive_buttons(floor_bit(4'd4), floor_bit(4'd6), 5);
        @(posedge clock);
        emergency_btn <= 1'b0;
        wait_idle();

        // Power drop with requests pending and door buttons held
        drive_buttons(floor_bit(4'd3), floor_bit(4'd10), 2);
        power_switch   <= 1'b0;
        door_open_btn  <= 1'b1;
        door_close_btn <= 1'b1;
        @(posedge clock);
        power_switch   <= 1'b1;
        door_open_btn  <= 1'b0;
        door_close_btn <= 1'b0;
        repeat (10) @(posedge clock);
        wait_idle();

        repeat (random_cycles) begin
            rand_state  = lcg_next(rand_state);
            press_floor = floor_t'(rand_state[26:20] % num_floors);
            @(posedge clock);
            call_buttons   <= (rand_state[31:28] == 4'h0 && rand_state[27]) ?
                              floor_bit(press_floor) : '0;
            panel_buttons  <= (rand_state[31:28] == 4'h0 && !rand_state[27]) ?
                              floor_bit(press_floor) : '0;
            door_open_btn  <= rand_state[5];
            door_close_btn <= rand_state[6];
            emergency_btn  <= (rand_state[15:11] == 5'd0);
        end
        @(posedge clock);
        call_buttons  <= '0;
        panel_buttons <= '0;
        emergency_btn <= 1'b0;
        wait_idle();
        repeat (5) @(posedge clock);
        $display("=== PASS ===");
        $finish;
    end

    // Watchdog
    initial begin
        #((test_cycles + margin_cycles) * clock_period);
        $display("Timeout: the run did not finish within %0d cycles",
                 test_cycles + margin_cycles);
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- floor_request_controller.f
rtl/elevator_pkg.sv
rtl/request_latch.sv
rtl/request_queue.sv
rtl/car_dispatch.sv
rtl/floor_request_controller.sv
bench/floor_request_controller_tb.sv

//--- Bender.yml
package:
  name: floor_request_controller

sources:
  - files:
      - rtl/elevator_pkg.sv
      - rtl/request_latch.sv
      - rtl/request_queue.sv
      - rtl/car_dispatch.sv
      - rtl/floor_request_controller.sv
  - target: simulation
    files:
      - bench/floor_request_controller_tb.sv
